/* core_settings.svh */
//////////////////////////////////////////////////////////////////////
// core settings
// datapath width, register count and reset vector for the
// rv32i subset pipeline
//////////////////////////////////////////////////////////////////////

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data and address width, one word per fetch
`define CORE_XLEN 32

// integer register file depth, x0 hardwired to zero
`define CORE_NREGS 32

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

/* core_pkg.sv */
//////////////////////////////////////////////////////////////////////
// core types
// instruction views, decoded control word and the pipeline
// register layouts shared by all stages
//////////////////////////////////////////////////////////////////////

`include "core_settings.svh"

package core_pkg;

  ////////////////////////////////////////////////////////////////////
  // instruction formats, one fetched word seen five ways
  ////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rType;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iType;

  typedef struct packed {
    logic [6:0] immHi;     // imm[11:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;     // imm[4:0]
    logic [6:0] opcode;
  } sType;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4to1;
    logic       imm11;     // odd spot, rv encoding
    logic [6:0] opcode;
  } bType;

  typedef struct packed {
    logic [19:0] imm;      // upper 20 bits
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uType;

  typedef union packed {
    rType r;
    iType i;
    sType s;
    bType b;
    uType u;
  } instrWord;

  ////////////////////////////////////////////////////////////////////
  // control and pipeline registers
  ////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluPassB
  } aluOpE;

  typedef struct packed {
    aluOpE aluOp;
    logic  useImm;         // imm replaces operand b
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  branch;
    logic  brNe;           // bne, else beq
  } ctrlWord;

  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] pc;
    instrWord              instr;
  } fdReg;

  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] pc;
    ctrlWord               ctrl;
    logic [`CORE_XLEN-1:0] rs1Val;
    logic [`CORE_XLEN-1:0] rs2Val;
    logic [`CORE_XLEN-1:0] imm;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [4:0]            rd;
  } deReg;

  typedef struct packed {
    logic                  valid;
    logic                  regWrite;
    logic                  memRead;
    logic                  memWrite;
    logic [`CORE_XLEN-1:0] aluRes;    // also the data address
    logic [`CORE_XLEN-1:0] storeData;
    logic [4:0]            rd;
  } emReg;

  typedef struct packed {
    logic                  we;
    logic [4:0]            rd;
    logic [`CORE_XLEN-1:0] data;
  } wbReq;

  typedef struct packed {
    logic stallF;
    logic stallD;
    logic flushD;
    logic flushE;
  } hazardCtl;

endpackage

/* fetchStage.sv */
//////////////////////////////////////////////////////////////////////
// fetch stage
// pc register, next pc select and the fetch/decode register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_settings.svh"

module fetchStage (
  input  logic                  clk,
  input  logic                  rstN,
  input  core_pkg::hazardCtl    hz,
  input  logic                  brTaken,
  input  logic [`CORE_XLEN-1:0] brTarget,
  output logic [`CORE_XLEN-1:0] imemAddr,
  input  core_pkg::instrWord    imemData,
  output core_pkg::fdReg        fd
);

  logic [`CORE_XLEN-1:0] pc;
  logic [`CORE_XLEN-1:0] pcNext;

  // redirect wins over sequential fetch
  assign pcNext   = brTaken ? brTarget : pc + `CORE_XLEN'(4);
  assign imemAddr = pc;     // imem answers same cycle

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= `CORE_RESET_PC;
    end else if (!hz.stallF) begin    // hold on load-use
      pc <= pcNext;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // fetch/decode register
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      fd.valid <= 1'b0;
    end else if (hz.flushD) begin
      fd.valid <= 1'b0;               // wrong-path word after a branch
    end else if (!hz.stallD) begin
      fd.valid <= 1'b1;
    end
    if (!hz.stallD) begin
      fd.pc    <= pc;
      fd.instr <= imemData;
    end
  end

endmodule

/* decodeStage.sv */
//////////////////////////////////////////////////////////////////////
// decode stage
// instruction decode, immediate build, register file with
// write-first read, and the decode/execute register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_settings.svh"

module decodeStage (
  input  logic               clk,
  input  logic               rstN,
  input  core_pkg::hazardCtl hz,
  input  core_pkg::fdReg     fd,
  input  core_pkg::wbReq     wb,
  output logic [4:0]         rs1D,
  output logic [4:0]         rs2D,
  output logic               useRs1D,
  output logic               useRs2D,
  output core_pkg::deReg     de
);

  localparam logic [6:0] opReg    = 7'b0110011;
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;

  core_pkg::instrWord    ins;
  core_pkg::ctrlWord     ctrl;
  logic [`CORE_XLEN-1:0] imm;
  logic                  useRs1, useRs2;
  logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];
  logic [`CORE_XLEN-1:0] rs1Val, rs2Val;

  assign ins = fd.instr;

  ////////////////////////////////////////////////////////////////////
  // decoder, anything unknown falls out as a no-op
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    ctrl   = '0;
    imm    = '0;
    useRs1 = 1'b0;
    useRs2 = 1'b0;
    case (ins.r.opcode)
      opReg: begin
        ctrl.regWrite = 1'b1;
        useRs1        = 1'b1;
        useRs2        = 1'b1;
        case ({ins.r.funct7, ins.r.funct3})
          10'b0000000_000: ctrl.aluOp = core_pkg::aluAdd;
          10'b0100000_000: ctrl.aluOp = core_pkg::aluSub;
          10'b0000000_010: ctrl.aluOp = core_pkg::aluSlt;
          10'b0000000_100: ctrl.aluOp = core_pkg::aluXor;
          10'b0000000_110: ctrl.aluOp = core_pkg::aluOr;
          10'b0000000_111: ctrl.aluOp = core_pkg::aluAnd;
          default: begin          // bad funct, no effects
            ctrl.regWrite = 1'b0;
            useRs1        = 1'b0;
            useRs2        = 1'b0;
          end
        endcase
      end
      opImm, opLoad: begin
        if (ins.i.funct3 == ((ins.i.opcode == opLoad) ? 3'b010 : 3'b000)) begin  // addi / lw
          ctrl.useImm   = 1'b1;
          ctrl.regWrite = 1'b1;
          ctrl.memRead  = (ins.i.opcode == opLoad);
          useRs1        = 1'b1;
          imm           = {{20{ins.i.imm[11]}}, ins.i.imm};
        end
      end
      opLui: begin
        ctrl.aluOp    = core_pkg::aluPassB;
        ctrl.useImm   = 1'b1;
        ctrl.regWrite = 1'b1;
        imm           = {ins.u.imm, 12'h000};
      end
      opStore: begin
        if (ins.s.funct3 == 3'b010) begin    // sw only
          ctrl.useImm   = 1'b1;
          ctrl.memWrite = 1'b1;
          useRs1        = 1'b1;
          useRs2        = 1'b1;
          imm           = {{20{ins.s.immHi[6]}}, ins.s.immHi, ins.s.immLo};
        end
      end
      opBranch: begin
        if (ins.b.funct3[2:1] == 2'b00) begin   // beq, bne
          ctrl.branch = 1'b1;
          ctrl.brNe   = ins.b.funct3[0];
          useRs1      = 1'b1;
          useRs2      = 1'b1;
          imm = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11, ins.b.imm10to5,
                 ins.b.imm4to1, 1'b0};
        end
      end
      default: ;
    endcase
    if (ins.r.rd == 5'd0) ctrl.regWrite = 1'b0;   // writes to x0 vanish here
  end

  assign rs1D    = ins.r.rs1;
  assign rs2D    = ins.r.rs2;
  assign useRs1D = useRs1 & fd.valid;   // bubbles never stall
  assign useRs2D = useRs2 & fd.valid;

  ////////////////////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < `CORE_NREGS; i++) regs[i] <= '0;  // arch state starts at zero
    end else if (wb.we && wb.rd != 5'd0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  always_comb begin
    rs1Val = regs[ins.r.rs1];
    if (wb.we && wb.rd == ins.r.rs1) rs1Val = wb.data;   // write-first
    if (ins.r.rs1 == 5'd0) rs1Val = '0;
    rs2Val = regs[ins.r.rs2];
    if (wb.we && wb.rd == ins.r.rs2) rs2Val = wb.data;
    if (ins.r.rs2 == 5'd0) rs2Val = '0;
  end

  // decode/execute register, flushE drops a bubble in
  always_ff @(posedge clk) begin
    if (!rstN) begin
      de.valid <= 1'b0;
    end else begin
      de.valid <= fd.valid & ~hz.flushE;
    end
    de.pc     <= fd.pc;
    de.ctrl   <= ctrl;
    de.rs1Val <= rs1Val;
    de.rs2Val <= rs2Val;
    de.imm    <= imm;
    de.rs1    <= ins.r.rs1;
    de.rs2    <= ins.r.rs2;
    de.rd     <= ins.r.rd;
  end

endmodule

/* executeStage.sv */
//////////////////////////////////////////////////////////////////////
// execute stage
// operand forwarding, alu, branch resolve and the
// execute/memory register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_settings.svh"

module executeStage (
  input  logic                  clk,
  input  logic                  rstN,
  input  core_pkg::deReg        de,
  input  core_pkg::wbReq        wb,
  output logic                  brTaken,
  output logic [`CORE_XLEN-1:0] brTarget,
  output core_pkg::emReg        em
);

  logic [`CORE_XLEN-1:0] srcA, fwdB, srcB;
  logic [`CORE_XLEN-1:0] aluRes;
  logic                  srcEq;

  // mem stage first, then writeback, else the decode-time read
  function automatic logic [`CORE_XLEN-1:0] fwdSel(
    input logic [4:0]            idx,
    input logic [`CORE_XLEN-1:0] regVal,
    input core_pkg::emReg        emQ,
    input core_pkg::wbReq        wbQ
  );
    if (idx == 5'd0) return '0;
    if (emQ.valid && emQ.regWrite && emQ.rd == idx) return emQ.aluRes;
    if (wbQ.we && wbQ.rd == idx) return wbQ.data;
    return regVal;
  endfunction

  assign srcA = fwdSel(de.rs1, de.rs1Val, em, wb);
  assign fwdB = fwdSel(de.rs2, de.rs2Val, em, wb);
  assign srcB = de.ctrl.useImm ? de.imm : fwdB;

  ////////////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    aluRes = '0;
    case (de.ctrl.aluOp)
      core_pkg::aluAdd:   aluRes = srcA + srcB;    // also ld/st address
      core_pkg::aluSub:   aluRes = srcA - srcB;
      core_pkg::aluAnd:   aluRes = srcA & srcB;
      core_pkg::aluOr:    aluRes = srcA | srcB;
      core_pkg::aluXor:   aluRes = srcA ^ srcB;
      core_pkg::aluSlt:   aluRes[0] = $signed(srcA) < $signed(srcB);
      core_pkg::aluPassB: aluRes = srcB;           // lui
      default:            aluRes = '0;
    endcase
  end

  // branch compare on forwarded regs, not the imm path
  assign srcEq    = (srcA == fwdB);
  assign brTaken  = de.valid & de.ctrl.branch & (de.ctrl.brNe ? ~srcEq : srcEq);
  assign brTarget = de.pc + de.imm;

  // execute/memory register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      em.valid <= 1'b0;
    end else begin
      em.valid <= de.valid;
    end
    em.regWrite  <= de.ctrl.regWrite;
    em.memRead   <= de.ctrl.memRead;
    em.memWrite  <= de.ctrl.memWrite;
    em.aluRes    <= aluRes;
    em.storeData <= fwdB;    // sw data, forwarded
    em.rd        <= de.rd;
  end

endmodule

/* memStage.sv */
//////////////////////////////////////////////////////////////////////
// memory stage
// drives the data port and registers the writeback request
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_settings.svh"

module memStage (
  input  logic                  clk,
  input  logic                  rstN,
  input  core_pkg::emReg        em,
  output logic [`CORE_XLEN-1:0] dmemAddr,
  output logic [`CORE_XLEN-1:0] dmemWData,
  output logic                  dmemWe,
  input  logic [`CORE_XLEN-1:0] dmemRData,
  output core_pkg::wbReq        wb
);

  // data port, read is combinational
  assign dmemAddr  = em.aluRes;
  assign dmemWData = em.storeData;
  assign dmemWe    = em.valid & em.memWrite;   // one-cycle strobe

  ////////////////////////////////////////////////////////////////////
  // memory/writeback register
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wb.we <= 1'b0;
    end else begin
      wb.we <= em.valid & em.regWrite;
    end
    wb.rd   <= em.rd;
    wb.data <= em.memRead ? dmemRData : em.aluRes;  // load or alu
  end

endmodule

/* hazardUnit.sv */
//////////////////////////////////////////////////////////////////////
// hazard unit
// load-use stall and branch flush for every stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module hazardUnit (
  input  core_pkg::deReg     de,
  input  logic [4:0]         rs1D,
  input  logic [4:0]         rs2D,
  input  logic               useRs1D,
  input  logic               useRs2D,
  input  logic               brTaken,
  output core_pkg::hazardCtl hz
);

  logic loadUse;
  logic rs1Hit, rs2Hit;

  // load sitting in execute, its rd needed by decode
  assign rs1Hit  = useRs1D & (rs1D == de.rd);
  assign rs2Hit  = useRs2D & (rs2D == de.rd);
  assign loadUse = de.valid & de.ctrl.memRead & (de.rd != 5'd0) & (rs1Hit | rs2Hit);

  ////////////////////////////////////////////////////////////////////
  // controls
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    hz.stallF = loadUse & ~brTaken;   // branch beats the stall
    hz.stallD = loadUse & ~brTaken;
    hz.flushD = brTaken;              // kill fd slot
    hz.flushE = brTaken | loadUse;    // bubble into de
  end

endmodule

/* pipeCore.sv */
//////////////////////////////////////////////////////////////////////
// pipeline core
// five-stage rv32i subset, fetch through writeback, with the
// hazard unit driving all stall and flush controls
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_settings.svh"

module pipeCore (
  input  logic                  clk,
  input  logic                  rstN,
  // instruction port
  output logic [`CORE_XLEN-1:0] imemAddr,
  input  core_pkg::instrWord    imemData,
  // data port
  output logic [`CORE_XLEN-1:0] dmemAddr,
  output logic [`CORE_XLEN-1:0] dmemWData,
  output logic                  dmemWe,
  input  logic [`CORE_XLEN-1:0] dmemRData
);

  core_pkg::hazardCtl    hz;
  core_pkg::fdReg        fd;
  core_pkg::deReg        de;
  core_pkg::emReg        em;
  core_pkg::wbReq        wb;       // writeback, also a forward source
  logic                  brTaken;
  logic [`CORE_XLEN-1:0] brTarget;
  logic [4:0]            rs1D, rs2D;
  logic                  useRs1D, useRs2D;

  ////////////////////////////////////////////////////////////////////
  // stages
  ////////////////////////////////////////////////////////////////////
  fetchStage fetch (
    .clk, .rstN, .hz,
    .brTaken, .brTarget,
    .imemAddr, .imemData,
    .fd
  );  // pc and fetch/decode register

  decodeStage decode (
    .clk, .rstN, .hz,
    .fd, .wb,
    .rs1D, .rs2D, .useRs1D, .useRs2D,
    .de
  );  // decoder and register file

  executeStage execute (
    .clk, .rstN,
    .de, .wb,
    .brTaken, .brTarget,
    .em
  );  // alu, forwarding, branch resolve

  memStage mem (
    .clk, .rstN,
    .em,
    .dmemAddr, .dmemWData, .dmemWe, .dmemRData,
    .wb
  );  // data port and writeback register

  hazardUnit hzu (
    .de,
    .rs1D, .rs2D, .useRs1D, .useRs2D,
    .brTaken,
    .hz
  );  // global stall and flush

endmodule

/* pipeCore_assert.sv */
//////////////////////////////////////////////////////////////////////
// pipeline core checks
// concurrent assertions bound into the core, covering the data
// strobe, fetch alignment and the decode stall/flush controls
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_settings.svh"

module pipeCore_assert (
  input logic                  clk,
  input logic                  rstN,
  input logic                  dmemWe,
  input logic [`CORE_XLEN-1:0] imemAddr,
  input core_pkg::hazardCtl    hz
);

  int failCount = 0;   // failed checks so far

  // strobe always driven once out of reset
  weKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(dmemWe))
    else begin
      failCount++;
      $error("dmemWe unknown out of reset");
    end

  fetchAligned: assert property (@(posedge clk) disable iff (!rstN) imemAddr[1:0] == 2'b00)
    else begin
      failCount++;
      $error("fetch address not word aligned");
    end

  // branch wins, so a decode stall never meets a decode flush
  stallFlushExcl: assert property (@(posedge clk) disable iff (!rstN)
                                   !(hz.stallD && hz.flushD))
    else begin
      failCount++;
      $error("decode stall and flush raised together");
    end

  weQuietAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !dmemWe)
    else begin
      failCount++;
      $error("store strobe in the first cycle after reset");
    end

endmodule

/* pipeCore_tb.sv */
//////////////////////////////////////////////////////////////////////
// pipeline core testbench
// random rv32i subset programs, an instruction-set reference
// model, and a compare of every data-memory store
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "core_settings.svh"

module pipeCore_tb;

  localparam int progCount     = 20;
  localparam int cyclesPerProg = 300;
  localparam int cycleLimit    = progCount * cyclesPerProg;
  localparam logic [`CORE_XLEN-1:0] haltWord = 32'h0000_0063;   // beq x0, x0, 0
  // {funct7, funct3} of add, sub, slt, xor, or, and
  localparam logic [9:0] rFunct [6] = '{10'h000, 10'h100, 10'h002, 10'h004, 10'h006, 10'h007};

  typedef struct packed {
    logic [`CORE_XLEN-1:0] addr;
    logic [`CORE_XLEN-1:0] data;
  } storeRec;
  typedef storeRec storeList [$];

  logic                  clk = 1'b0;
  logic                  rstN;
  logic [`CORE_XLEN-1:0] imemAddr;
  core_pkg::instrWord    imemData;
  logic [`CORE_XLEN-1:0] dmemAddr, dmemWData, dmemRData;
  logic                  dmemWe;

  logic [`CORE_XLEN-1:0] imem [256];
  logic [`CORE_XLEN-1:0] dmem [64];
  storeList              expQ;      // stores still owed by the core
  storeRec               nextExp;
  int                    cycles = 0;

  pipeCore u_pipeCore (
    .clk, .rstN,
    .imemAddr, .imemData,
    .dmemAddr, .dmemWData, .dmemWe, .dmemRData
  );

  bind pipeCore pipeCore_assert coreChecks (.clk, .rstN, .dmemWe, .imemAddr, .hz);

  initial begin
    forever #4 clk = ~clk;   // 8 ns
  end

  //////////////////////////////////////////////////////////////////////
  // memory models, both read combinationally
  //////////////////////////////////////////////////////////////////////
  assign imemData  = imem[imemAddr[9:2]];
  assign dmemRData = dmem[dmemAddr[7:2]];   // word index from low bits

  always @(posedge clk) begin
    if (dmemWe === 1'b1) dmem[dmemAddr[7:2]] <= dmemWData;
  end

  function automatic logic [`CORE_XLEN-1:0] fillWord(input int idx);
    return 32'(idx) * 32'h9e37_79b9 + 32'h0bad_f00d;
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic checkAddr(input logic [`CORE_XLEN-1:0] got, input logic [`CORE_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH dmemAddr got %h expected %h", got, exp);
      abortRun("store address differs from the reference model");
    end
  endtask

  task automatic checkData(input logic [`CORE_XLEN-1:0] got, input logic [`CORE_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH dmemWData got %h expected %h", got, exp);
      abortRun("store data differs from the reference model");
    end
  endtask

  // program generator, random body then a dump of x1..x15 and a halt
  task automatic genProgram();
    int          nRand;
    int          kind;
    logic [4:0]  rd, rs1, rs2, lastRd;
    logic [9:0]  fn;
    logic [11:0] off;
    nRand  = 30 + $urandom_range(0, 20);
    lastRd = 5'd1;
    for (int i = 0; i < 256; i++) imem[i] = {25'(i), 7'h7f};   // undefined filler
    for (int i = 0; i < nRand; i++) begin
      rd  = 5'($urandom_range(0, 15));   // x0 now and then
      rs1 = 5'($urandom_range(0, 15));
      rs2 = 5'($urandom_range(0, 15));
      if ($urandom_range(0, 1) == 1) rs1 = lastRd;   // chain on previous result
      if ($urandom_range(0, 3) == 0) rs2 = lastRd;
      fn   = rFunct[$urandom_range(0, 5)];
      off  = 12'($urandom_range(0, 63) * 4);
      kind = $urandom_range(0, 9);
      if (kind == 8 && i >= nRand - 3) kind = 2;   // targets stay in the body
      case (kind)
        0, 1: imem[i] = {fn[9:3], rs2, rs1, fn[2:0], rd, 7'h33};
        3:    imem[i] = {20'($urandom), rd, 7'h37};                       // lui
        4:    imem[i] = {off, 5'd0, 3'b010, rd, 7'h03};                   // lw
        5:    imem[i] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'h23};  // sw
        6:    imem[i] = {7'h01, rs2, rs1, 3'b000, rd, 7'h33};             // mul
        7:    imem[i] = ($urandom_range(0, 1) == 1) ? {25'($urandom), 7'h0b}
                                                    : {12'($urandom), rs1, 3'b001, rd, 7'h13};
        8:    imem[i] = {7'b0, rs2, rs1, 2'b00, 1'($urandom),
                         (($urandom_range(0, 1) == 1) ? 4'b0100 : 4'b0110), 1'b0, 7'h63};
        default: imem[i] = {12'($urandom), rs1, 3'b000, rd, 7'h13};      // addi
      endcase
      lastRd = rd;
    end
    for (int r = 1; r < 16; r++) begin
      off = 12'(r * 4);
      imem[nRand + r - 1] = {off[11:5], 5'(r), 5'd0, 3'b010, off[4:0], 7'h23};
    end
    imem[nRand + 15] = haltWord;
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model, program order, own registers and memory
  //////////////////////////////////////////////////////////////////////
  function automatic storeList refRun();
    storeList              stores;
    logic [`CORE_XLEN-1:0] x [32];
    logic [`CORE_XLEN-1:0] mem [64];
    logic [`CORE_XLEN-1:0] pc, nextPc, ins, a, b, res, addr;
    logic                  doWr;
    int                    steps;
    for (int i = 0; i < 32; i++) x[i] = '0;
    for (int i = 0; i < 64; i++) mem[i] = fillWord(i);
    pc    = `CORE_RESET_PC;
    steps = 0;
    while (imem[pc[9:2]] != haltWord && steps < 256) begin
      ins    = imem[pc[9:2]];
      a      = x[ins[19:15]];
      b      = x[ins[24:20]];
      nextPc = pc + 4;
      doWr   = 1'b0;
      res    = '0;
      case (ins[6:0])
        7'h33: begin
          doWr = 1'b1;
          case ({ins[31:25], ins[14:12]})
            10'h000: res = a + b;
            10'h100: res = a - b;
            10'h002: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            10'h004: res = a ^ b;
            10'h006: res = a | b;
            10'h007: res = a & b;
            default: doWr = 1'b0;   // mul and the like
          endcase
        end
        7'h13: begin
          doWr = (ins[14:12] == 3'b000);   // addi only
          res  = a + {{20{ins[31]}}, ins[31:20]};
        end
        7'h37: begin
          doWr = 1'b1;
          res  = {ins[31:12], 12'h000};
        end
        7'h03: if (ins[14:12] == 3'b010) begin
          addr = a + {{20{ins[31]}}, ins[31:20]};
          doWr = 1'b1;
          res  = mem[addr[7:2]];
        end
        7'h23: if (ins[14:12] == 3'b010) begin
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          mem[addr[7:2]] = b;
          stores.push_back({addr, b});
        end
        7'h63: begin
          if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
            nextPc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
          end
        end
        default: ;
      endcase
      if (doWr && ins[11:7] != 5'd0) x[ins[11:7]] = res;   // x0 stays zero
      pc = nextPc;
      steps++;
    end
    return stores;
  endfunction

  // store compare, mid-cycle when the data port is settled
  always @(negedge clk) begin
    if (dmemWe === 1'b1) begin
      if (expQ.size() == 0) begin
        abortRun("store strobe with no store left in the reference list");
      end else begin
        nextExp = expQ.pop_front();
        checkAddr(dmemAddr, nextExp.addr);
        checkData(dmemWData, nextExp.data);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (u_pipeCore.coreChecks.failCount != 0) begin
      abortRun("a bound assertion on the core failed");
    end else if (cycles > cycleLimit) begin
      abortRun($sformatf("timeout after %0d cycles with stores still pending", cycles));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(32'hc1bd66b9));
    for (int p = 0; p < progCount; p++) begin
      rstN = 1'b0;
      @(negedge clk);                            // old program drained by the first reset edge
      genProgram();
      for (int i = 0; i < 64; i++) dmem[i] = fillWord(i);
      expQ = refRun();
      repeat (7) @(negedge clk);                 // eight reset cycles in all
      rstN = 1'b1;
      while (expQ.size() != 0) @(posedge clk);   // emptied by the compare process
      repeat (6) @(negedge clk);                 // stray strobes show up here
    end
    if (u_pipeCore.coreChecks.failCount == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1, "bound assertions failed");
    end
  end

endmodule

/* compile.f */
+incdir+.
core_pkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memStage.sv
hazardUnit.sv
pipeCore.sv
pipeCore_assert.sv
pipeCore_tb.sv
